/* src/trdb_defs.svh */
// widths and limits of the trace encoder, pulled in with `include by RTL and testbench files
`ifndef TRDB_DEFS_SVH
`define TRDB_DEFS_SVH

// core retirement view
`define TRDB_PC_LEN 32
`define TRDB_INST_LEN 32
`define TRDB_CAUSE_LEN 5
`define TRDB_TVAL_LEN 32
`define TRDB_PRIV_LEN 2

// branch map sizing, count must reach the full capacity
`define TRDB_BRANCH_MAP_LEN 8
`define TRDB_BRANCH_COUNT_LEN 4

// packets between two forced sync packets
`define TRDB_RESYNC_MAX 6

// packet output, payload in bits and length in bytes
`define TRDB_PAYLOAD_LEN 80
`define TRDB_LENGTH_LEN 4

// rv32 major opcodes of control transfer instructions
`define TRDB_OPC_BRANCH 7'b1100011
`define TRDB_OPC_JAL 7'b1101111
`define TRDB_OPC_JALR 7'b1100111

`endif

/* src/trdb_core_pkg.sv */
// types for the retirement view of the core, imported by the history stage and the encoder
`include "trdb_defs.svh"

package trdb_core_pkg;

    // instruction class after opcode decode
    typedef enum logic [1:0] {
        ITYPE_OTHER  = 2'd0,
        ITYPE_BRANCH = 2'd1,
        ITYPE_JAL    = 2'd2,
        ITYPE_JALR   = 2'd3
    } trdb_itype_e;

    // privilege level as reported by the core
    // 2 is reserved by the spec
    typedef enum logic [`TRDB_PRIV_LEN-1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } trdb_priv_e;

endpackage

/* src/trdb_pkg.sv */
// types for the trace packets, imported by the encoder, the top level and the testbench
package trdb_pkg;

    // packet format in the type field
    // format 0 is optional and not produced
    typedef enum logic [1:0] {
        F_ADDR_BRANCH = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_e;

    // subformat of a sync packet, first payload field
    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } trdb_sync_subformat_e;

endpackage

/* src/trdb_inst_history.sv */
// samples the core each cycle into next/this/last slots and derives the encoder events
`include "trdb_defs.svh"

module trdb_inst_history import trdb_core_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // core retirement view
    input  logic                        inst_valid_i,
    input  logic                        exception_i,
    input  logic                        interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0]  cause_i,
    input  logic [`TRDB_TVAL_LEN-1:0]   tval_i,
    input  logic [`TRDB_PRIV_LEN-1:0]   priv_lvl_i,
    input  logic [`TRDB_INST_LEN-1:0]   inst_data_i,
    input  logic [`TRDB_PC_LEN-1:0]     pc_i,
    input  logic                        trace_enable_i,
    // events of the this-cycle instruction
    output logic                        tc_qualified_o,
    output logic                        first_qualified_o,
    output logic                        final_qualified_o,
    output logic                        privchange_o,
    output logic                        tc_branch_o,
    output logic                        tc_taken_o,
    output logic [`TRDB_PC_LEN-1:0]     tc_iaddr_o,
    output trdb_priv_e                  tc_priv_o,
    // last-cycle instruction
    output logic                        lc_exception_o,
    output logic                        lc_interrupt_o,
    output logic [`TRDB_CAUSE_LEN-1:0]  lc_cause_o,
    output logic [`TRDB_TVAL_LEN-1:0]   lc_tval_o,
    output logic                        lc_updiscon_o
);

    // slot index, new samples enter at nc
    localparam int unsigned NC = 0;
    localparam int unsigned TC = 1;
    localparam int unsigned LC = 2;

    logic [2:0]                         valid_q;
    logic [2:0]                         qual_q;
    logic [2:0]                         exc_q;
    logic [2:0]                         intr_q;
    logic [2:0][`TRDB_CAUSE_LEN-1:0]    cause_q;
    logic [2:0][`TRDB_TVAL_LEN-1:0]     tval_q;
    logic [2:0][`TRDB_PRIV_LEN-1:0]     priv_q;
    // the address is not needed any more once the slot reaches lc
    logic [1:0][`TRDB_PC_LEN-1:0]       iaddr_q;
    trdb_itype_e                        itype_q [3];
    trdb_itype_e                        itype_d;
    logic [6:0]                         opcode;

    // opcode decode, invalid cycles carry no class
    assign opcode = inst_data_i[6:0];

    always_comb begin
        itype_d = ITYPE_OTHER;
        if (inst_valid_i) begin
            case (opcode)
                `TRDB_OPC_BRANCH: itype_d = ITYPE_BRANCH;
                `TRDB_OPC_JAL:    itype_d = ITYPE_JAL;
                `TRDB_OPC_JALR:   itype_d = ITYPE_JALR;
                default:          itype_d = ITYPE_OTHER;
            endcase
        end
    end

    // three stage shift, flags of an invalid cycle are forced low on entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            qual_q  <= '0;
            exc_q   <= '0;
            intr_q  <= '0;
            cause_q <= '0;
            tval_q  <= '0;
            priv_q  <= '0;
            iaddr_q <= '0;
            itype_q <= '{default: ITYPE_OTHER};
        end else begin
            valid_q <= {valid_q[1:0], inst_valid_i};
            qual_q  <= {qual_q[1:0], inst_valid_i & trace_enable_i};
            exc_q   <= {exc_q[1:0], inst_valid_i & exception_i};
            intr_q  <= {intr_q[1:0], inst_valid_i & interrupt_i};
            cause_q <= {cause_q[1:0], cause_i};
            tval_q  <= {tval_q[1:0], tval_i};
            priv_q  <= {priv_q[1:0], priv_lvl_i};
            iaddr_q <= {iaddr_q[0], pc_i};
            itype_q[LC] <= itype_q[TC];
            itype_q[TC] <= itype_q[NC];
            itype_q[NC] <= itype_d;
        end
    end

    // qualification edges seen from tc
    assign tc_qualified_o    = qual_q[TC];
    assign first_qualified_o = qual_q[TC] & ~qual_q[LC];
    assign final_qualified_o = qual_q[TC] & ~qual_q[NC];
    assign privchange_o      = valid_q[LC] & (priv_q[LC] != priv_q[TC]);

    assign tc_iaddr_o = iaddr_q[TC];
    assign tc_priv_o  = trdb_priv_e'(priv_q[TC]);

    // every instruction is 4 bytes, anything else in nc means the branch was taken
    assign tc_branch_o = qual_q[TC] & (itype_q[TC] == ITYPE_BRANCH);
    assign tc_taken_o  = iaddr_q[NC] != (iaddr_q[TC] + `TRDB_PC_LEN'(4));

    // trap info and uninferable jump of the previous instruction
    assign lc_exception_o = exc_q[LC];
    assign lc_interrupt_o = intr_q[LC];
    assign lc_cause_o     = cause_q[LC];
    assign lc_tval_o      = tval_q[LC];
    assign lc_updiscon_o  = itype_q[LC] == ITYPE_JALR;

endmodule

/* src/trdb_branch_map.sv */
// collects taken/not-taken bits of branches until the encoder flushes them into a packet
`include "trdb_defs.svh"

module trdb_branch_map (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // tc branch and its outcome
    input  logic                                branch_i,
    input  logic                                taken_i,
    // packet emitted this cycle
    input  logic                                flush_i,
    output logic [`TRDB_BRANCH_COUNT_LEN-1:0]   count_o,
    output logic [`TRDB_BRANCH_MAP_LEN-1:0]     map_o,
    output logic                                full_o
);

    logic [`TRDB_BRANCH_COUNT_LEN-1:0]  count_q;
    logic [`TRDB_BRANCH_MAP_LEN-1:0]    map_q;

    // current view already holds the tc branch
    // oldest branch sits at bit 0, new ones land above it
    always_comb begin
        count_o = count_q;
        map_o   = map_q;
        if (branch_i) begin
            count_o = count_q + `TRDB_BRANCH_COUNT_LEN'(1);
            map_o   = map_q | (`TRDB_BRANCH_MAP_LEN'(taken_i) << count_q);
        end
    end

    assign full_o = count_o == `TRDB_BRANCH_COUNT_LEN'(`TRDB_BRANCH_MAP_LEN);

    // flush wins, the tc bit leaves with the packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
            map_q   <= '0;
        end else if (flush_i) begin
            count_q <= '0;
            map_q   <= '0;
        end else begin
            count_q <= count_o;
            map_q   <= map_o;
        end
    end

endmodule

/* src/trdb_packet_encoder.sv */
// picks the packet for the tc instruction, builds its payload and counts packets for resync
`include "trdb_defs.svh"

module trdb_packet_encoder import trdb_pkg::*, trdb_core_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // history view
    input  logic                                tc_qualified_i,
    input  logic                                first_qualified_i,
    input  logic                                final_qualified_i,
    input  logic                                privchange_i,
    input  logic [`TRDB_PC_LEN-1:0]             tc_iaddr_i,
    input  trdb_priv_e                          tc_priv_i,
    input  logic                                lc_exception_i,
    input  logic                                lc_interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0]          lc_cause_i,
    input  logic [`TRDB_TVAL_LEN-1:0]           lc_tval_i,
    input  logic                                lc_updiscon_i,
    // branch map view
    input  logic [`TRDB_BRANCH_COUNT_LEN-1:0]   branch_count_i,
    input  logic [`TRDB_BRANCH_MAP_LEN-1:0]     branch_map_i,
    input  logic                                map_full_i,
    output logic                                flush_o,
    // packet port
    output logic                                packet_valid_o,
    output trdb_format_e                        packet_type_o,
    output logic [`TRDB_LENGTH_LEN-1:0]         packet_length_o,
    output logic [`TRDB_PAYLOAD_LEN-1:0]        packet_payload_o
);

    localparam int unsigned RESYNC_W = $clog2(`TRDB_RESYNC_MAX + 1);

    logic                               emit;
    trdb_format_e                       fmt;
    trdb_sync_subformat_e               sub;
    logic [RESYNC_W-1:0]                resync_q;
    logic                               resync_max;
    logic [`TRDB_PAYLOAD_LEN-1:0]       payload;
    logic [`TRDB_LENGTH_LEN-1:0]        length;

    assign resync_max = resync_q == RESYNC_W'(`TRDB_RESYNC_MAX);

    // priority, only a qualified tc can emit
    always_comb begin
        emit = 1'b0;
        fmt  = F_ADDR_ONLY;
        sub  = SF_START;
        if (tc_qualified_i) begin
            if (first_qualified_i || privchange_i || resync_max) begin
                emit = 1'b1;
                fmt  = F_SYNC;
            end else if (lc_exception_i) begin
                // tc is the first handler instruction
                emit = 1'b1;
                fmt  = F_SYNC;
                sub  = SF_TRAP;
            end else if (lc_updiscon_i || final_qualified_i || map_full_i) begin
                emit = 1'b1;
                fmt  = (branch_count_i != '0) ? F_ADDR_BRANCH : F_ADDR_ONLY;
            end
        end
    end

    // payload fields packed from bit 0, upper bits stay zero
    always_comb begin
        payload = '0;
        length  = '0;
        case (fmt)
            F_SYNC: begin
                if (sub == SF_TRAP) begin
                    payload = `TRDB_PAYLOAD_LEN'({tc_iaddr_i, lc_tval_i, lc_cause_i,
                                                  lc_interrupt_i, tc_priv_i, sub});
                    // 74 bits
                    length  = `TRDB_LENGTH_LEN'(10);
                end else begin
                    payload = `TRDB_PAYLOAD_LEN'({tc_iaddr_i, tc_priv_i, sub});
                    // 36 bits
                    length  = `TRDB_LENGTH_LEN'(5);
                end
            end
            F_ADDR_BRANCH: begin
                payload = `TRDB_PAYLOAD_LEN'({tc_iaddr_i, branch_map_i, branch_count_i});
                // 44 bits
                length  = `TRDB_LENGTH_LEN'(6);
            end
            default: begin
                payload = `TRDB_PAYLOAD_LEN'(tc_iaddr_i);
                length  = `TRDB_LENGTH_LEN'(4);
            end
        endcase
    end

    // map clears on the same edge that registers the packet
    assign flush_o = emit;

    // control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
            resync_q       <= '0;
        end else begin
            packet_valid_o <= emit;
            if (emit) begin
                // any sync packet restarts the count
                resync_q <= (fmt == F_SYNC) ? '0 : resync_q + RESYNC_W'(1);
            end
        end
    end

    // packet data, only meaningful with packet_valid_o
    always_ff @(posedge clk_i) begin
        if (emit) begin
            packet_type_o    <= fmt;
            packet_length_o  <= length;
            packet_payload_o <= payload;
        end
    end

endmodule

/* src/trace_debugger.sv */
// top level of the trace encoder, connects the core retirement port to the packet port
`include "trdb_defs.svh"

module trace_debugger import trdb_pkg::*, trdb_core_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // core retirement port
    input  logic                            inst_valid_i,
    input  logic                            exception_i,
    input  logic                            interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0]      cause_i,
    input  logic [`TRDB_TVAL_LEN-1:0]       tval_i,
    input  logic [`TRDB_PRIV_LEN-1:0]       priv_lvl_i,
    input  logic [`TRDB_INST_LEN-1:0]       inst_data_i,
    input  logic [`TRDB_PC_LEN-1:0]         pc_i,
    input  logic                            trace_enable_i,
    // packet port, one cycle pulse and no back-pressure
    output logic                            packet_valid_o,
    output trdb_format_e                    packet_type_o,
    output logic [`TRDB_LENGTH_LEN-1:0]     packet_length_o,
    output logic [`TRDB_PAYLOAD_LEN-1:0]    packet_payload_o
);

    // history to encoder
    logic                               tc_qualified;
    logic                               first_qualified;
    logic                               final_qualified;
    logic                               privchange;
    logic [`TRDB_PC_LEN-1:0]            tc_iaddr;
    trdb_priv_e                         tc_priv;
    logic                               lc_exception;
    logic                               lc_interrupt;
    logic [`TRDB_CAUSE_LEN-1:0]         lc_cause;
    logic [`TRDB_TVAL_LEN-1:0]          lc_tval;
    logic                               lc_updiscon;
    // history to branch map
    logic                               tc_branch;
    logic                               tc_taken;
    // branch map and encoder
    logic [`TRDB_BRANCH_COUNT_LEN-1:0]  branch_count;
    logic [`TRDB_BRANCH_MAP_LEN-1:0]    branch_map;
    logic                               map_full;
    logic                               flush;

    trdb_inst_history i_history (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .inst_valid_i      (inst_valid_i),
        .exception_i       (exception_i),
        .interrupt_i       (interrupt_i),
        .cause_i           (cause_i),
        .tval_i            (tval_i),
        .priv_lvl_i        (priv_lvl_i),
        .inst_data_i       (inst_data_i),
        .pc_i              (pc_i),
        .trace_enable_i    (trace_enable_i),
        .tc_qualified_o    (tc_qualified),
        .first_qualified_o (first_qualified),
        .final_qualified_o (final_qualified),
        .privchange_o      (privchange),
        .tc_branch_o       (tc_branch),
        .tc_taken_o        (tc_taken),
        .tc_iaddr_o        (tc_iaddr),
        .tc_priv_o         (tc_priv),
        .lc_exception_o    (lc_exception),
        .lc_interrupt_o    (lc_interrupt),
        .lc_cause_o        (lc_cause),
        .lc_tval_o         (lc_tval),
        .lc_updiscon_o     (lc_updiscon)
    );

    trdb_branch_map i_branch_map (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .branch_i (tc_branch),
        .taken_i  (tc_taken),
        .flush_i  (flush),
        .count_o  (branch_count),
        .map_o    (branch_map),
        .full_o   (map_full)
    );

    trdb_packet_encoder i_encoder (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .tc_qualified_i    (tc_qualified),
        .first_qualified_i (first_qualified),
        .final_qualified_i (final_qualified),
        .privchange_i      (privchange),
        .tc_iaddr_i        (tc_iaddr),
        .tc_priv_i         (tc_priv),
        .lc_exception_i    (lc_exception),
        .lc_interrupt_i    (lc_interrupt),
        .lc_cause_i        (lc_cause),
        .lc_tval_i         (lc_tval),
        .lc_updiscon_i     (lc_updiscon),
        .branch_count_i    (branch_count),
        .branch_map_i      (branch_map),
        .map_full_i        (map_full),
        .flush_o           (flush),
        .packet_valid_o    (packet_valid_o),
        .packet_type_o     (packet_type_o),
        .packet_length_o   (packet_length_o),
        .packet_payload_o  (packet_payload_o)
    );

endmodule

/* sim/tb_clock_gen.sv */
// free running testbench clock, instantiated once by the testbench top
module tb_clock_gen #(
    parameter int unsigned PERIOD = 8
) (
    output logic clk_o
);

    // low at time zero, first rising edge after half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

/* sim/trace_debugger_checker.sv */
// concurrent assertions on the packet port, attached to trace_debugger by bind in the testbench
`include "trdb_defs.svh"

module trace_debugger_checker import trdb_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            packet_valid_i,
    input  trdb_format_e                    packet_type_i,
    input  logic [`TRDB_LENGTH_LEN-1:0]     packet_length_i
);

    // number of assertion failures so far
    int fail_count = 0;

    // history has to fill nc and tc before anything can leave
    a_quiet_after_reset: assert property (
        @(posedge clk_i) $rose(rst_ni) |-> !packet_valid_i ##1 !packet_valid_i
    ) else begin
        $error("packet_valid_o high within two cycles of reset release");
        fail_count++;
    end

    // valid must always be driven
    a_valid_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !$isunknown(packet_valid_i)
    ) else begin
        $error("packet_valid_o is unknown");
        fail_count++;
    end

    // bare address packet is four bytes
    a_addr_only_length: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (packet_valid_i && packet_type_i == F_ADDR_ONLY)
            |-> packet_length_i == `TRDB_LENGTH_LEN'(4)
    ) else begin
        $error("address-only packet with length %0d", packet_length_i);
        fail_count++;
    end

    // start sync is 5 bytes and trap sync 10
    a_sync_length: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (packet_valid_i && packet_type_i == F_SYNC)
            |-> (packet_length_i == `TRDB_LENGTH_LEN'(5)
                 || packet_length_i == `TRDB_LENGTH_LEN'(10))
    ) else begin
        $error("sync packet with length %0d", packet_length_i);
        fail_count++;
    end

endmodule

/* sim/trace_debugger_tb.sv */
// self-checking testbench for trace_debugger, applies a per-cycle table and checks each packet
`include "trdb_defs.svh"

module trace_debugger_tb import trdb_pkg::*, trdb_core_pkg::*; ();

    localparam int unsigned PERIOD = 8;
    // one edge to sample and two more to the registered packet
    localparam int LATENCY = 3;
    // addi x0, x0, 0
    localparam logic [`TRDB_INST_LEN-1:0] OP_OTHER  = 32'h0000_0013;
    // beq x0, x0, 0
    localparam logic [`TRDB_INST_LEN-1:0] OP_BRANCH = 32'h0000_0063;
    // jalr x0, 0(x1)
    localparam logic [`TRDB_INST_LEN-1:0] OP_JALR   = 32'h0000_8067;

    // one cycle of core view plus the packet it should cause
    typedef struct packed {
        logic                           valid;
        logic                           en;
        logic                           exc;
        logic                           intr;
        logic [`TRDB_CAUSE_LEN-1:0]     cause;
        logic [`TRDB_TVAL_LEN-1:0]      tval;
        logic [`TRDB_PRIV_LEN-1:0]      priv;
        logic [`TRDB_INST_LEN-1:0]      inst;
        logic [`TRDB_PC_LEN-1:0]        pc;
        logic                           exp_valid;
        logic [1:0]                     exp_type;
        logic [`TRDB_LENGTH_LEN-1:0]    exp_len;
        logic [`TRDB_PAYLOAD_LEN-1:0]   exp_payload;
    } row_t;

    logic                           clk;
    logic                           rst_n;
    logic                           inst_valid;
    logic                           exception;
    logic                           interrupt;
    logic [`TRDB_CAUSE_LEN-1:0]     cause;
    logic [`TRDB_TVAL_LEN-1:0]      tval;
    logic [`TRDB_PRIV_LEN-1:0]      priv_lvl;
    logic [`TRDB_INST_LEN-1:0]      inst_data;
    logic [`TRDB_PC_LEN-1:0]        pc;
    logic                           trace_enable;
    logic                           packet_valid;
    trdb_format_e                   packet_type;
    logic [`TRDB_LENGTH_LEN-1:0]    packet_length;
    logic [`TRDB_PAYLOAD_LEN-1:0]   packet_payload;

    row_t   rows [$];
    int     checks = 0;
    int     errors = 0;

    tb_clock_gen #(.PERIOD(PERIOD)) i_clock (.clk_o(clk));

    trace_debugger uut (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .inst_valid_i     (inst_valid),
        .exception_i      (exception),
        .interrupt_i      (interrupt),
        .cause_i          (cause),
        .tval_i           (tval),
        .priv_lvl_i       (priv_lvl),
        .inst_data_i      (inst_data),
        .pc_i             (pc),
        .trace_enable_i   (trace_enable),
        .packet_valid_o   (packet_valid),
        .packet_type_o    (packet_type),
        .packet_length_o  (packet_length),
        .packet_payload_o (packet_payload)
    );

    bind trace_debugger trace_debugger_checker i_checker (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .packet_valid_i  (packet_valid_o),
        .packet_type_i   (packet_type_o),
        .packet_length_i (packet_length_o)
    );

    task automatic add_row(input logic valid, input logic en, input logic [`TRDB_PC_LEN-1:0] addr,
                           input logic [`TRDB_INST_LEN-1:0] inst,
                           input logic [`TRDB_PRIV_LEN-1:0] priv);
        row_t r;
        r       = '0;
        r.valid = valid;
        r.en    = en;
        r.pc    = addr;
        r.inst  = inst;
        r.priv  = priv;
        rows.push_back(r);
    endtask

    // marks the newest row as a trapping instruction
    task automatic add_trap(input logic intr, input logic [`TRDB_CAUSE_LEN-1:0] code,
                            input logic [`TRDB_TVAL_LEN-1:0] value);
        row_t r;
        r       = rows.pop_back();
        r.exc   = 1'b1;
        r.intr  = intr;
        r.cause = code;
        r.tval  = value;
        rows.push_back(r);
    endtask

    // packet expected for the newest row
    task automatic expect_packet(input trdb_format_e fmt, input logic [`TRDB_LENGTH_LEN-1:0] len,
                                 input logic [`TRDB_PAYLOAD_LEN-1:0] payload);
        row_t r;
        r             = rows.pop_back();
        r.exp_valid   = 1'b1;
        r.exp_type    = fmt;
        r.exp_len     = len;
        r.exp_payload = payload;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [`TRDB_PC_LEN-1:0] addr;
        add_row(1'b0, 1'b0, 32'h0, OP_OTHER, PRIV_M);
        // first qualified instruction once tracing starts
        add_row(1'b1, 1'b1, 32'h0000_1000, OP_OTHER, PRIV_M);
        expect_packet(F_SYNC, 4'd5, 80'({32'h0000_1000, PRIV_M, SF_START}));
        // not taken, taken, then indirect jump
        add_row(1'b1, 1'b1, 32'h0000_1004, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_1008, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_1020, OP_JALR, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_2000, OP_OTHER, PRIV_M);
        expect_packet(F_ADDR_BRANCH, 4'd6, 80'({32'h0000_2000, 8'b0000_0010, 4'd2}));
        // indirect jump with nothing pending
        add_row(1'b1, 1'b1, 32'h0000_2004, OP_JALR, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_3000, OP_OTHER, PRIV_M);
        expect_packet(F_ADDR_ONLY, 4'd4, 80'(32'h0000_3000));
        // eight branches with taken bits 0, 3 and 7
        add_row(1'b1, 1'b1, 32'h0000_3004, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_3100, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_3104, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_3108, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_3200, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_3204, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_3208, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_320c, OP_BRANCH, PRIV_M);
        expect_packet(F_ADDR_BRANCH, 4'd6, 80'({32'h0000_320c, 8'b1000_1001, 4'd8}));
        // one not-taken branch in the restarted map
        add_row(1'b1, 1'b1, 32'h0000_3300, OP_BRANCH, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_3304, OP_JALR, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_4000, OP_OTHER, PRIV_M);
        expect_packet(F_ADDR_BRANCH, 4'd6, 80'({32'h0000_4000, 8'b0000_0000, 4'd1}));
        // timer interrupt reported by the handler at 0x800
        add_row(1'b1, 1'b1, 32'h0000_4004, OP_OTHER, PRIV_M);
        add_trap(1'b1, 5'd7, 32'hdead_beef);
        add_row(1'b1, 1'b1, 32'h0000_0800, OP_OTHER, PRIV_M);
        expect_packet(F_SYNC, 4'd10,
                      80'({32'h0000_0800, 32'hdead_beef, 5'd7, 1'b1, PRIV_M, SF_TRAP}));
        // drop to user mode
        add_row(1'b1, 1'b1, 32'h0000_0804, OP_OTHER, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_0808, OP_JALR, PRIV_M);
        add_row(1'b1, 1'b1, 32'h0000_5000, OP_OTHER, PRIV_U);
        expect_packet(F_SYNC, 4'd5, 80'({32'h0000_5000, PRIV_U, SF_START}));
        // chain of jumps with one address packet each until resync is due
        add_row(1'b1, 1'b1, 32'h0000_5004, OP_JALR, PRIV_U);
        for (int k = 0; k < `TRDB_RESYNC_MAX; k++) begin
            addr = 32'h0000_6000 + 32'(k) * 32'h0000_0100;
            add_row(1'b1, 1'b1, addr, OP_JALR, PRIV_U);
            expect_packet(F_ADDR_ONLY, 4'd4, 80'(addr));
        end
        add_row(1'b1, 1'b1, 32'h0000_6600, OP_OTHER, PRIV_U);
        expect_packet(F_SYNC, 4'd5, 80'({32'h0000_6600, PRIV_U, SF_START}));
        // last qualified is a not-taken branch before tracing stops
        add_row(1'b1, 1'b1, 32'h0000_6604, OP_BRANCH, PRIV_U);
        expect_packet(F_ADDR_BRANCH, 4'd6, 80'({32'h0000_6604, 8'b0000_0000, 4'd1}));
        add_row(1'b1, 1'b0, 32'h0000_6608, OP_OTHER, PRIV_U);
        add_row(1'b1, 1'b0, 32'h0000_660c, OP_JALR, PRIV_U);
        add_row(1'b1, 1'b0, 32'h0000_7000, OP_OTHER, PRIV_U);
        add_row(1'b0, 1'b0, 32'h0, OP_OTHER, PRIV_U);
    endtask

    task automatic apply_row(input row_t r);
        inst_valid   = r.valid;
        trace_enable = r.en;
        exception    = r.exc;
        interrupt    = r.intr;
        cause        = r.cause;
        tval         = r.tval;
        priv_lvl     = r.priv;
        inst_data    = r.inst;
        pc           = r.pc;
    endtask

    task automatic check_value(input string name, input logic [`TRDB_PAYLOAD_LEN-1:0] got,
                               input logic [`TRDB_PAYLOAD_LEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // data fields only carry meaning with a valid packet
    task automatic check_packet(input row_t r);
        check_value("packet_valid_o", 80'(packet_valid), 80'(r.exp_valid));
        if (r.exp_valid) begin
            check_value("packet_type_o", 80'(packet_type), 80'(r.exp_type));
            check_value("packet_length_o", 80'(packet_length), 80'(r.exp_len));
            check_value("packet_payload_o", packet_payload, r.exp_payload);
        end
    endtask

    initial begin
        row_t idle;
        idle  = '0;
        rst_n = 1'b0;
        apply_row(idle);
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // drive row i and check the row whose packet is due now
        for (int i = 0; i < rows.size() + LATENCY; i++) begin
            @(posedge clk);
            #1;
            if (i >= LATENCY) begin
                check_packet(rows[i - LATENCY]);
            end
            if (i < rows.size()) begin
                apply_row(rows[i]);
            end else begin
                apply_row(idle);
            end
        end
        $display("checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.i_checker.fail_count);
        if (errors == 0 && uut.i_checker.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // the table is complete one unit after time zero
    initial begin
        #1;
        #((rows.size() + 20) * PERIOD);
        $display("watchdog expired: the table did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+src
src/trdb_core_pkg.sv
src/trdb_pkg.sv
src/trdb_inst_history.sv
src/trdb_branch_map.sv
src/trdb_packet_encoder.sv
src/trace_debugger.sv
sim/tb_clock_gen.sv
sim/trace_debugger_checker.sv
sim/trace_debugger_tb.sv

/* Makefile */
TOP := trace_debugger_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
